//--- common/pdec_mem_pkg.sv
// fixed host map: 13-bit word address, 3-bit region in bits 12:10, no alternative map
package pdec_mem_pkg;

  // ==========================================================================
  // host bus
  // ==========================================================================
  localparam int host_addr_w = 13;
  localparam int host_data_w = 32;

  // region field sits on top of the host address
  localparam int region_lsb  = 10;
  localparam int region_w    = 3;

  // ==========================================================================
  // region codes
  // ==========================================================================
  localparam logic [region_w-1:0] region_para0 = 3'd0;  // parameter region 0
  localparam logic [region_w-1:0] region_para1 = 3'd1;  // parameter region 1
  localparam logic [region_w-1:0] region_drm0  = 3'd2;  // llr bank 0
  localparam logic [region_w-1:0] region_drm1  = 3'd3;  // llr bank 1
  localparam logic [region_w-1:0] region_dec   = 3'd4;  // decision results, read only

  // ==========================================================================
  // depths
  // ==========================================================================
  localparam int drm0_depth      = 192;
  localparam int drm1_depth      = 480;

  // both parameter regions share one array
  localparam int para_depth      = 1026;
  localparam int para_region_ofs = 513;  // first word of region 1

  localparam int dec_depth       = 15;

  // ==========================================================================
  // address widths
  // ==========================================================================
  localparam int drm_addr_w      = 6;  // decoder read index
  localparam int drm_waddr_w     = 9;  // host write index, low bits of host address

  // per bank array index
  localparam int drm0_addr_w     = $clog2(drm0_depth);
  localparam int drm1_addr_w     = $clog2(drm1_depth);

  localparam int para_addr_w     = 10;  // index inside one region
  localparam int para_mem_addr_w = 11;  // index into the shared array

  localparam int dec_addr_w      = 4;

  // byte lanes of a decision word
  localparam int dec_lanes       = 4;

endpackage

//--- common/pdec_llr_pkg.sv
// llr is a 6-bit field, four per bank word; request structs are single-cycle, no handshake
package pdec_llr_pkg;

  localparam int llr_w = 6;

  typedef logic [llr_w-1:0] llr_t;

  // one bank entry, llr3 in the top field
  typedef struct packed {
    llr_t llr3;
    llr_t llr2;
    llr_t llr1;
    llr_t llr0;
  } drm_word_t;

  // eight llrs to the decoder
  typedef struct packed {
    drm_word_t bank1;
    drm_word_t bank0;
  } drm_rdata_t;

  typedef logic [pdec_mem_pkg::host_data_w-1:0] para_word_t;

  // ==========================================================================
  // requests
  // ==========================================================================
  typedef struct packed {
    logic                                   en;
    logic [pdec_mem_pkg::host_addr_w-1:0]   addr;
    logic [pdec_mem_pkg::host_data_w-1:0]   data;
  } host_wr_t;

  typedef struct packed {
    logic                                   en;
    logic [pdec_mem_pkg::host_addr_w-1:0]   addr;
  } host_rd_t;

  typedef struct packed {
    logic                                   en0;   // bank 0
    logic                                   en1;   // bank 1
    logic [pdec_mem_pkg::drm_waddr_w-1:0]   addr;
    drm_word_t                              data;
  } drm_wr_t;

  typedef struct packed {
    logic                                   en;
    logic                                   region;  // 1 = upper region
    logic [pdec_mem_pkg::para_addr_w-1:0]   index;
  } para_wr_t;

  // checker write, one byte per lane
  typedef struct packed {
    logic                                   en;
    logic [pdec_mem_pkg::dec_addr_w-1:0]    addr;
    logic [pdec_mem_pkg::dec_lanes-1:0]     wbyte;
    logic [pdec_mem_pkg::dec_lanes-1:0][7:0] data;
  } dec_wr_t;

endpackage

//--- rtl/sram_ff.sv
// flop-based single port; write beats read, rdata follows the last read address, no reset
module sram_ff #(
  parameter type word_t = logic [31:0],
  parameter int  depth  = 16
) (
  input  logic                     clk,
  input  logic                     ce,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] addr,
  input  word_t                    wdata,
  output word_t                    rdata
);

  word_t                    mem [depth];
  logic [$clog2(depth)-1:0] addr_q;  // read address, held between reads

  always_ff @(posedge clk) begin
    if (ce) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        addr_q <= addr;
      end
    end
  end

  // data shows up the cycle after the read strobe
  assign rdata = mem[addr_q];

  // callers map host and decoder indices, both must land inside the array
  a_addr_in_range: assert property (@(posedge clk) ce |-> (addr < depth))
    else $error("sram_ff: address %0d beyond depth %0d", addr, depth);

endmodule

//--- rtl/pdec_addr_decode.sv
// purely combinational; host writes to region 4 and above are dropped, reads only hit region 4
module pdec_addr_decode (
  input  pdec_llr_pkg::host_wr_t               host_wr,
  input  pdec_llr_pkg::host_rd_t               host_rd,
  output pdec_llr_pkg::drm_wr_t                drm_wr,
  output pdec_llr_pkg::para_wr_t               para_wr,
  output pdec_llr_pkg::para_word_t             para_wdata,
  output logic                                 dec_ren,
  output logic [pdec_mem_pkg::dec_addr_w-1:0]  dec_raddr
);
  import pdec_mem_pkg::*;
  import pdec_llr_pkg::*;

  logic [region_w-1:0] wr_region;
  logic [region_w-1:0] rd_region;
  drm_word_t           llr_word;

  assign wr_region = host_wr.addr[region_lsb +: region_w];
  assign rd_region = host_rd.addr[region_lsb +: region_w];

  // each llr lives in the low bits of its byte, top two bits dropped
  always_comb begin
    llr_word.llr3 = host_wr.data[24 +: llr_w];
    llr_word.llr2 = host_wr.data[16 +: llr_w];
    llr_word.llr1 = host_wr.data[8 +: llr_w];
    llr_word.llr0 = host_wr.data[0 +: llr_w];
  end

  // ==========================================================================
  // write side
  // ==========================================================================
  always_comb begin
    drm_wr        = '0;
    drm_wr.addr   = host_wr.addr[drm_waddr_w-1:0];
    drm_wr.data   = llr_word;
    para_wr       = '0;
    para_wr.index = host_wr.addr[para_addr_w-1:0];
    if (host_wr.en) begin
      case (wr_region)
        region_para0: para_wr.en = 1'b1;
        region_para1: begin
          para_wr.en     = 1'b1;
          para_wr.region = 1'b1;
        end
        region_drm0:  drm_wr.en0 = 1'b1;
        region_drm1:  drm_wr.en1 = 1'b1;
        default:      ;  // unmapped, ignore
      endcase
    end
  end

  assign para_wdata = host_wr.data;  // parameters go in unchanged

  // ==========================================================================
  // read side
  // ==========================================================================
  assign dec_ren   = host_rd.en && (rd_region == region_dec);
  assign dec_raddr = host_rd.addr[dec_addr_w-1:0];

endmodule

//--- drm/drm_llr_buf.sv
// both banks read the same index; a write in the same cycle as a read drops that bank's read
module drm_llr_buf (
  input  logic                                clk,
  input  logic                                rst_n,
  input  pdec_llr_pkg::drm_wr_t               drm_wr,
  input  logic                                ren,
  input  logic [pdec_mem_pkg::drm_addr_w-1:0] raddr,
  output pdec_llr_pkg::drm_rdata_t            rdata
);
  import pdec_mem_pkg::*;
  import pdec_llr_pkg::*;

  logic [drm0_addr_w-1:0] addr0;
  logic [drm1_addr_w-1:0] addr1;
  drm_word_t              rd0;
  drm_word_t              rd1;
  logic                   ren_q;

  // ==========================================================================
  // banks
  // ==========================================================================
  // host write index wins over the decoder index
  assign addr0 = drm_wr.en0 ? drm_wr.addr[drm0_addr_w-1:0] : drm0_addr_w'(raddr);
  assign addr1 = drm_wr.en1 ? drm_wr.addr[drm1_addr_w-1:0] : drm1_addr_w'(raddr);

  sram_ff #(
    .word_t (drm_word_t),
    .depth  (drm0_depth)
  ) u_bank0 (
    .clk   (clk),
    .ce    (drm_wr.en0 | ren),
    .we    (drm_wr.en0),
    .addr  (addr0),
    .wdata (drm_wr.data),
    .rdata (rd0)
  );

  sram_ff #(
    .word_t (drm_word_t),
    .depth  (drm1_depth)
  ) u_bank1 (
    .clk   (clk),
    .ce    (drm_wr.en1 | ren),
    .we    (drm_wr.en1),
    .addr  (addr1),
    .wdata (drm_wr.data),
    .rdata (rd1)
  );

  // ==========================================================================
  // output hold
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ren_q <= 1'b0;
    end else begin
      ren_q <= ren;  // lines up with the array read data
    end
  end

  // llr7..llr4 from bank 1, llr3..llr0 from bank 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (ren_q) begin
      rdata.bank1 <= rd1;
      rdata.bank0 <= rd0;
    end
  end

endmodule

//--- rtl/para_buf.sv
// one port for two regions; only one access per cycle is served, reads lose to writes
module para_buf (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  pdec_llr_pkg::para_wr_t               para_wr,
  input  pdec_llr_pkg::para_word_t             wdata,
  input  logic [1:0]                           ren,
  input  logic [pdec_mem_pkg::para_addr_w-1:0] raddr,
  output pdec_llr_pkg::para_word_t             rdata
);
  import pdec_mem_pkg::*;
  import pdec_llr_pkg::*;

  logic [para_mem_addr_w-1:0] region1_base;
  logic [para_mem_addr_w-1:0] mem_addr;
  logic                       mem_ce;
  para_word_t                 mem_rdata;
  logic                       ren_q;

  assign region1_base = para_mem_addr_w'(para_region_ofs);

  // ==========================================================================
  // access arbitration
  // ==========================================================================
  // write region 0, write region 1, read region 0, read region 1
  always_comb begin
    if (para_wr.en && !para_wr.region) begin
      mem_addr = para_mem_addr_w'(para_wr.index);
    end else if (para_wr.en) begin
      mem_addr = para_mem_addr_w'(para_wr.index) + region1_base;
    end else if (ren[0]) begin
      mem_addr = para_mem_addr_w'(raddr);
    end else if (ren[1]) begin
      mem_addr = para_mem_addr_w'(raddr) + region1_base;
    end else begin
      mem_addr = '0;
    end
  end

  assign mem_ce = para_wr.en | (|ren);

  sram_ff #(
    .word_t (para_word_t),
    .depth  (para_depth)
  ) u_mem (
    .clk   (clk),
    .ce    (mem_ce),
    .we    (para_wr.en),
    .addr  (mem_addr),
    .wdata (wdata),
    .rdata (mem_rdata)
  );

  // ==========================================================================
  // output hold
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ren_q <= 1'b0;
    end else begin
      ren_q <= (|ren) & ~para_wr.en;  // read actually issued
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (ren_q) begin
      rdata <= mem_rdata;
    end
  end

endmodule

//--- rtl/dec_result_ram.sv
// checker writes by byte lane, host reads whole words; write and read must not share a cycle
module dec_result_ram (
  input  logic                                 clk,
  input  pdec_llr_pkg::dec_wr_t                dec_wr,
  input  logic                                 ren,
  input  logic [pdec_mem_pkg::dec_addr_w-1:0]  raddr,
  output logic [pdec_mem_pkg::host_data_w-1:0] rdata
);
  import pdec_mem_pkg::*;
  import pdec_llr_pkg::*;

  logic [dec_lanes-1:0][7:0] mem [dec_depth];
  logic [dec_addr_w-1:0]     raddr_q;

  // ==========================================================================
  // array
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (dec_wr.en) begin
      for (int i = 0; i < dec_lanes; i++) begin
        if (dec_wr.wbyte[i]) begin
          mem[dec_wr.addr][i] <= dec_wr.data[i];  // untouched lanes keep old bytes
        end
      end
    end else if (ren) begin
      raddr_q <= raddr;
    end
  end

  assign rdata = mem[raddr_q];  // one cycle after the host read

  // checker and host bus share the single port
  a_no_collision: assert property (@(posedge clk) !(dec_wr.en && ren))
    else $error("dec_result_ram: checker write and host read in one cycle");

endmodule

//--- rtl/pdec_sram_top.sv
// no back-pressure anywhere; drm and para read data lag the enable by two cycles, host by one
module pdec_sram_top (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // host bus
  input  pdec_llr_pkg::host_wr_t                host_wr,
  input  pdec_llr_pkg::host_rd_t                host_rd,
  output logic [pdec_mem_pkg::host_data_w-1:0]  host_rdata,

  // decoder llr read
  input  logic                                  drm_ren,
  input  logic [pdec_mem_pkg::drm_addr_w-1:0]   drm_raddr,
  output pdec_llr_pkg::drm_rdata_t              drm_rdata,

  // parameter read, bit 0 region 0, bit 1 region 1
  input  logic [1:0]                            para_ren,
  input  logic [pdec_mem_pkg::para_addr_w-1:0]  para_raddr,
  output pdec_llr_pkg::para_word_t              para_rdata,

  // checker write
  input  pdec_llr_pkg::dec_wr_t                 dec_wr
);
  import pdec_mem_pkg::*;
  import pdec_llr_pkg::*;

  drm_wr_t                drm_wr;
  para_wr_t               para_wr;
  para_word_t             para_wdata;
  logic                   dec_ren;
  logic [dec_addr_w-1:0]  dec_raddr;

  // ==========================================================================
  // decode
  // ==========================================================================
  pdec_addr_decode u_decode (
    .host_wr    (host_wr),
    .host_rd    (host_rd),
    .drm_wr     (drm_wr),
    .para_wr    (para_wr),
    .para_wdata (para_wdata),
    .dec_ren    (dec_ren),
    .dec_raddr  (dec_raddr)
  );

  // ==========================================================================
  // memory stages
  // ==========================================================================
  drm_llr_buf u_drm (
    .clk    (clk),
    .rst_n  (rst_n),
    .drm_wr (drm_wr),
    .ren    (drm_ren),
    .raddr  (drm_raddr),
    .rdata  (drm_rdata)
  );

  para_buf u_para (
    .clk     (clk),
    .rst_n   (rst_n),
    .para_wr (para_wr),
    .wdata   (para_wdata),
    .ren     (para_ren),
    .raddr   (para_raddr),
    .rdata   (para_rdata)
  );

  dec_result_ram u_dec (
    .clk    (clk),
    .dec_wr (dec_wr),
    .ren    (dec_ren),
    .raddr  (dec_raddr),
    .rdata  (host_rdata)  // valid one cycle after the host read
  );

endmodule

//--- verif/tb_pdec_sram.sv
// replays verif/pdec_sram_testdata.txt from the project root; stops at the first mismatch
module tb_pdec_sram;
  import pdec_mem_pkg::*;
  import pdec_llr_pkg::*;

  logic                   clk = 1'b0;
  logic                   rst_n;
  host_wr_t               host_wr;
  host_rd_t               host_rd;
  logic [host_data_w-1:0] host_rdata;
  logic                   drm_ren;
  logic [drm_addr_w-1:0]  drm_raddr;
  drm_rdata_t             drm_rdata;
  logic [1:0]             para_ren;
  logic [para_addr_w-1:0] para_raddr;
  para_word_t             para_rdata;
  dec_wr_t                dec_wr;

  // parsed operations, one entry per data line
  byte         op_q [$];
  logic [63:0] a_q [$];
  logic [63:0] b_q [$];
  logic [63:0] c_q [$];
  logic [63:0] exp_drm  = '0;  // last drm value read back
  logic [63:0] exp_para = '0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 1000;

  pdec_sram_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_wr    (host_wr),
    .host_rd    (host_rd),
    .host_rdata (host_rdata),
    .drm_ren    (drm_ren),
    .drm_raddr  (drm_raddr),
    .drm_rdata  (drm_rdata),
    .para_ren   (para_ren),
    .para_raddr (para_raddr),
    .para_rdata (para_rdata),
    .dec_wr     (dec_wr)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      abort_run("timeout: operations did not finish within the cycle limit");
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error: time %0t %s expected %h got %h", $time, name, exp, got);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #10;  // inputs change away from the edge
  endtask

  task automatic clear_inputs();
    host_wr    = '0;
    host_rd    = '0;
    drm_ren    = 1'b0;
    drm_raddr  = '0;
    para_ren   = 2'b00;
    para_raddr = '0;
    dec_wr     = '0;
  endtask

  task automatic load_testdata();
    int          fd;
    int          cnt;
    int          need;
    string       tok;
    logic [63:0] f1;
    logic [63:0] f2;
    logic [63:0] f3;
    logic [1023:0] line_buf;
    fd = $fopen("verif/pdec_sram_testdata.txt", "r");
    if (fd == 0) abort_run("cannot open verif/pdec_sram_testdata.txt");
    while ($fscanf(fd, "%s", tok) == 1) begin
      f1 = '0;
      f2 = '0;
      f3 = '0;
      cnt = 0;
      need = 0;
      case (tok[0])
        "#": void'($fgets(line_buf, fd));  // comment, drop rest of line
        "W", "D", "R": begin
          need = 2;
          cnt = $fscanf(fd, "%h %h", f1, f2);
        end
        "C", "P": begin
          need = 3;
          cnt = $fscanf(fd, "%h %h %h", f1, f2, f3);
        end
        "I": ;
        default: abort_run({"unknown operation code in data file: ", tok});
      endcase
      if (cnt != need) abort_run({"missing fields after operation ", tok});
      if (tok[0] != "#") begin
        op_q.push_back(tok[0]);
        a_q.push_back(f1);
        b_q.push_back(f2);
        c_q.push_back(f3);
      end
    end
    $fclose(fd);
  endtask

  // ==========================================================================
  // one data line
  // ==========================================================================
  task automatic run_op(input byte op, input logic [63:0] a, input logic [63:0] b,
                        input logic [63:0] c);
    clear_inputs();
    case (op)
      "W": begin
        host_wr = '{en: 1'b1, addr: a[host_addr_w-1:0], data: b[31:0]};
        step_cycle();
      end
      "C": begin
        dec_wr = '{en: 1'b1, addr: a[dec_addr_w-1:0], wbyte: b[3:0], data: c[31:0]};
        step_cycle();
      end
      "D": begin
        drm_ren   = 1'b1;
        drm_raddr = a[drm_addr_w-1:0];
        step_cycle();
        clear_inputs();
        step_cycle();  // array read, then hold register
        exp_drm = 64'(b[47:0]);
        check_value("drm_rdata", 64'(drm_rdata), exp_drm);
      end
      "P": begin
        para_ren   = a[0] ? 2'b10 : 2'b01;
        para_raddr = b[para_addr_w-1:0];
        step_cycle();
        clear_inputs();
        step_cycle();
        exp_para = 64'(c[31:0]);
        check_value("para_rdata", 64'(para_rdata), exp_para);
      end
      "R": begin
        host_rd = '{en: 1'b1, addr: a[host_addr_w-1:0]};
        step_cycle();
        check_value("host_rdata", 64'(host_rdata), 64'(b[31:0]));
      end
      default: begin
        step_cycle();  // idle, outputs must hold
        check_value("drm_rdata", 64'(drm_rdata), exp_drm);
        check_value("para_rdata", 64'(para_rdata), exp_para);
      end
    endcase
    clear_inputs();
  endtask

  initial begin
    rst_n = 1'b0;
    clear_inputs();
    load_testdata();
    cycle_limit = op_q.size() * 4 + 20;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    check_value("drm_rdata", 64'(drm_rdata), 64'd0);  // reset values
    check_value("para_rdata", 64'(para_rdata), 64'd0);
    for (int i = 0; i < op_q.size(); i++) begin
      run_op(op_q[i], a_q[i], b_q[i], c_q[i]);
    end
    if (op_q.size() == 0) begin
      abort_run("data file holds no operations");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- verif/pdec_sram_testdata.txt
# W addr data | C addr wbyte data | D raddr expect | P region index expect
# R addr expect | I idle, drm and para outputs must hold (all fields hex)
I
W 805 3f2a1501
W c05 c7ffb2d9
D 05 1ffc99fea541
I
I
W 007 deadbeef
W 407 12345678
P 0 007 deadbeef
I
P 1 007 12345678
W 828 01020304
W c28 3f3f3f3f
I
D 28 ffffff0420c4
W 600 a5a50001
P 1 200 a5a50001
I
C 3 f 11223344
R 1003 11223344
C 3 5 aabbccdd
I
R 1003 11bb33dd
D 05 1ffc99fea541
I

//--- pdec_sram.f
common/pdec_mem_pkg.sv
common/pdec_llr_pkg.sv
rtl/sram_ff.sv
rtl/pdec_addr_decode.sv
drm/drm_llr_buf.sv
rtl/para_buf.sv
rtl/dec_result_ram.sv
rtl/pdec_sram_top.sv
verif/tb_pdec_sram.sv

//--- run_sim.sh
#!/bin/sh
# build and run from the project root so the data file path resolves
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pdec_sram -f pdec_sram.f -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation failed"; exit 1; }
